// File: design/alu.sv
module alu (
	input logic [rvCorePkg::xlen-1:0] srcA_i,
	input logic [rvCorePkg::xlen-1:0] srcB_i,
	input rvCorePkg::aluOpE aluOp_i,
	output logic [rvCorePkg::xlen-1:0] aluResult_o,
	output logic aluZero_o
);
	import rvCorePkg::*;

	logic subtract;
	logic [xlen-1:0] bOperand;
	logic [xlen-1:0] sum;
	logic carryOut;
	logic overflow;
	logic lessSigned;
	logic lessUnsigned;

	// sub, slt and sltu all have bit 0 set
	assign subtract = aluOp_i[0];
	assign bOperand = subtract ? ~srcB_i : srcB_i;
	assign {carryOut, sum} = {1'b0, srcA_i} + {1'b0, bOperand} + {{xlen{1'b0}}, subtract};

	// Operands of equal sign but result of the other sign
	assign overflow = (srcA_i[xlen-1] ~^ bOperand[xlen-1]) & (srcA_i[xlen-1] ^ sum[xlen-1]);
	assign lessSigned = sum[xlen-1] ^ overflow;
	assign lessUnsigned = ~carryOut;	// Borrow out of a - b

	always_comb begin
		case (aluOp_i)
			aluAdd, aluSub: aluResult_o = sum;
			aluAnd: aluResult_o = srcA_i & srcB_i;
			aluOr: aluResult_o = srcA_i | srcB_i;
			aluXor: aluResult_o = srcA_i ^ srcB_i;
			aluSlt: aluResult_o = {{(xlen-1){1'b0}}, lessSigned};
			aluSltu: aluResult_o = {{(xlen-1){1'b0}}, lessUnsigned};
			aluSll: aluResult_o = srcA_i << srcB_i[4:0];
			aluSrl: aluResult_o = srcA_i >> srcB_i[4:0];
			aluSra: aluResult_o = $signed(srcA_i) >>> srcB_i[4:0];
			default: aluResult_o = '0;
		endcase
	end

	assign aluZero_o = ~|aluResult_o;

endmodule : alu

// File: design/controlUnit.sv
module controlUnit (
	input logic [rvCorePkg::xlen-1:0] instr_i,
	input logic [rvCorePkg::xlen-1:0] aluResult_i,
	input logic aluZero_i,
	output rvCorePkg::decodeT decode_o,
	output rvCorePkg::pcSelE pcSel_o
);
	import rvCorePkg::*;

	opcodeE opcode;
	logic [2:0] funct3;
	logic altBit;	// funct7[5], sub and sra
	immSelE immSel;
	logic branchTaken;

	logic [xlen-1:0] immI;
	logic [xlen-1:0] immS;
	logic [xlen-1:0] immB;
	logic [xlen-1:0] immU;
	logic [xlen-1:0] immJ;

	assign opcode = opcodeE'(instr_i[6:0]);
	assign funct3 = instr_i[14:12];
	assign altBit = instr_i[30];

	assign immI = {{21{instr_i[31]}}, instr_i[30:20]};
	assign immS = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
	assign immB = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign immU = {instr_i[31:12], 12'b0};
	assign immJ = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// Shared by R-type and I-type ALU ops
	function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic alt);
		aluOpE op;
		case (f3)
			3'b000: op = alt ? aluSub : aluAdd;
			3'b001: op = aluSll;
			3'b010: op = aluSlt;
			3'b011: op = aluSltu;
			3'b100: op = aluXor;
			3'b101: op = alt ? aluSra : aluSrl;
			3'b110: op = aluOr;
			default: op = aluAnd;
		endcase
		return op;
	endfunction

	always_comb begin
		decode_o.rs1 = instr_i[19:15];
		decode_o.rs2 = instr_i[24:20];
		decode_o.rd = instr_i[11:7];
		decode_o.regWrite = 1'b0;
		decode_o.memWrite = 1'b0;
		decode_o.aluSrcImm = 1'b0;
		decode_o.aluOp = aluAdd;
		decode_o.resultSel = resAlu;
		immSel = immFmtI;

		case (opcode)
			opRType: begin
				decode_o.regWrite = 1'b1;
				decode_o.aluOp = aluFromFunct(funct3, altBit);
			end
			opImm: begin
				decode_o.regWrite = 1'b1;
				decode_o.aluSrcImm = 1'b1;
				// No subi, bit 30 only selects sra here
				decode_o.aluOp = aluFromFunct(funct3, altBit && funct3 == 3'b101);
			end
			opLoad: begin	// Word loads only
				decode_o.regWrite = 1'b1;
				decode_o.aluSrcImm = 1'b1;
				decode_o.resultSel = resMem;
			end
			opStore: begin
				decode_o.memWrite = 1'b1;
				decode_o.aluSrcImm = 1'b1;
				immSel = immFmtS;
			end
			opBranch: begin
				immSel = immFmtB;
				case (funct3)
					3'b100, 3'b101: decode_o.aluOp = aluSlt;
					3'b110, 3'b111: decode_o.aluOp = aluSltu;
					default: decode_o.aluOp = aluSub;	// beq, bne use the zero flag
				endcase
			end
			opJal: begin
				decode_o.regWrite = 1'b1;
				decode_o.resultSel = resPcPlus4;
				immSel = immFmtJ;
			end
			opJalr: begin
				decode_o.regWrite = 1'b1;
				decode_o.aluSrcImm = 1'b1;
				decode_o.resultSel = resPcPlus4;
			end
			opLui: begin
				decode_o.regWrite = 1'b1;
				decode_o.resultSel = resImm;
				immSel = immFmtU;
			end
			opAuipc: begin
				decode_o.regWrite = 1'b1;
				decode_o.resultSel = resPcTarget;
				immSel = immFmtU;
			end
			default: begin	// System, FENCE and unknown opcodes write nothing
				decode_o.regWrite = 1'b0;
			end
		endcase

		case (immSel)
			immFmtS: decode_o.imm = immS;
			immFmtB: decode_o.imm = immB;
			immFmtU: decode_o.imm = immU;
			immFmtJ: decode_o.imm = immJ;
			default: decode_o.imm = immI;
		endcase
	end

	// Compare bit comes back in bit 0 for slt/sltu
	always_comb begin
		case (funct3)
			3'b000: branchTaken = aluZero_i;
			3'b001: branchTaken = !aluZero_i;
			3'b100, 3'b110: branchTaken = aluResult_i[0];
			3'b101, 3'b111: branchTaken = !aluResult_i[0];
			default: branchTaken = 1'b0;
		endcase
	end

	always_comb begin
		case (opcode)
			opBranch: pcSel_o = branchTaken ? pcSrcTarget : pcSrcPlus4;
			opJal: pcSel_o = pcSrcTarget;
			opJalr: pcSel_o = pcSrcAlu;
			opSystem: pcSel_o = pcSrcHold;
			default: pcSel_o = pcSrcPlus4;
		endcase
	end

endmodule : controlUnit

// File: design/pcUnit.sv
module pcUnit (
	input logic clk,
	input logic rst,
	input rvCorePkg::pcSelE pcSel_i,
	input logic [rvCorePkg::xlen-1:0] imm_i,
	input logic [rvCorePkg::xlen-1:0] aluResult_i,
	output logic [rvCorePkg::xlen-1:0] pc_o,
	output logic [rvCorePkg::xlen-1:0] pcPlus4_o,
	output logic [rvCorePkg::xlen-1:0] pcTarget_o
);
	import rvCorePkg::*;

	logic [xlen-1:0] pcNext;

	assign pcPlus4_o = pc_o + xlen'(4);
	assign pcTarget_o = pc_o + imm_i;	// Branch, JAL and AUIPC

	always_comb begin
		case (pcSel_i)
			pcSrcTarget: pcNext = pcTarget_o;
			pcSrcAlu: pcNext = {aluResult_i[xlen-1:1], 1'b0};	// JALR drops bit 0
			pcSrcHold: pcNext = pc_o;
			default: pcNext = pcPlus4_o;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc_o <= '0;
		end else begin
			pc_o <= pcNext;
		end
	end

	// Branch and jump offsets must keep the PC on a word boundary
	pcAligned: assert property (@(posedge clk) disable iff (rst)
		pc_o[1:0] == 2'b00);

endmodule : pcUnit

// File: design/regFile.sv
module regFile (
	input logic clk,
	input logic rst,
	input logic we_i,
	input logic [rvCorePkg::regAddrW-1:0] rs1_i,
	input logic [rvCorePkg::regAddrW-1:0] rs2_i,
	input logic [rvCorePkg::regAddrW-1:0] rd_i,
	input logic [rvCorePkg::xlen-1:0] wd_i,
	output logic [rvCorePkg::xlen-1:0] rd1_o,
	output logic [rvCorePkg::xlen-1:0] rd2_o
);
	import rvCorePkg::*;

	logic [xlen-1:0] regs [numRegs];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && rd_i != '0) begin	// x0 never written
			regs[rd_i] <= wd_i;
		end
	end

	// Asynchronous reads, x0 reads zero
	assign rd1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign rd2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

	// An unknown index would corrupt an arbitrary register
	writeAddrKnown: assert property (@(posedge clk) disable iff (rst)
		we_i |-> !$isunknown(rd_i));

endmodule : regFile

// File: design/rvCore.sv
module rvCore (
	input logic clk,
	input logic rst,
	output logic [rvCorePkg::xlen-1:0] imemAddr_o,
	input logic [rvCorePkg::xlen-1:0] imemRd_i,
	output logic [rvCorePkg::xlen-1:0] dmemAddr_o,
	output logic [rvCorePkg::xlen-1:0] dmemWd_o,
	output logic dmemWe_o,
	input logic [rvCorePkg::xlen-1:0] dmemRd_i
);
	import rvCorePkg::*;

	decodeT decode;
	pcSelE pcSel;

	logic [xlen-1:0] rd1;
	logic [xlen-1:0] rd2;
	logic [xlen-1:0] srcB;
	logic [xlen-1:0] aluResult;
	logic aluZero;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] pcPlus4;
	logic [xlen-1:0] pcTarget;
	logic [xlen-1:0] result;	// Writeback value

	controlUnit u_controlUnit (
		.instr_i(imemRd_i),
		.aluResult_i(aluResult),
		.aluZero_i(aluZero),
		.decode_o(decode),
		.pcSel_o(pcSel)
	);

	regFile u_regFile (
		.clk(clk),
		.rst(rst),
		.we_i(decode.regWrite),
		.rs1_i(decode.rs1),
		.rs2_i(decode.rs2),
		.rd_i(decode.rd),
		.wd_i(result),
		.rd1_o(rd1),
		.rd2_o(rd2)
	);

	assign srcB = decode.aluSrcImm ? decode.imm : rd2;

	alu u_alu (
		.srcA_i(rd1),
		.srcB_i(srcB),
		.aluOp_i(decode.aluOp),
		.aluResult_o(aluResult),
		.aluZero_o(aluZero)
	);

	pcUnit u_pcUnit (
		.clk(clk),
		.rst(rst),
		.pcSel_i(pcSel),
		.imm_i(decode.imm),
		.aluResult_i(aluResult),
		.pc_o(pc),
		.pcPlus4_o(pcPlus4),
		.pcTarget_o(pcTarget)
	);

	always_comb begin
		case (decode.resultSel)
			resMem: result = dmemRd_i;
			resPcPlus4: result = pcPlus4;	// Link for JAL/JALR
			resImm: result = decode.imm;
			resPcTarget: result = pcTarget;
			default: result = aluResult;
		endcase
	end

	assign imemAddr_o = pc;
	assign dmemAddr_o = aluResult;	// rs1 + imm for loads and stores
	assign dmemWd_o = rd2;
	assign dmemWe_o = decode.memWrite & ~rst;	// No store leaves the core in reset

	// Branch resolution loops through the ALU, so an X here reaches the PC
	pcSelKnown: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(pcSel));

	aluOpDefined: assert property (@(posedge clk) disable iff (rst)
		decode.aluOp inside {aluAdd, aluSub, aluAnd, aluOr, aluXor,
			aluSlt, aluSll, aluSrl, aluSra, aluSltu});

endmodule : rvCore

// File: design/rvCorePkg.sv
package rvCorePkg;

	localparam int xlen = 32;	// Data and address width
	localparam int regAddrW = 5;
	localparam int numRegs = 32;

	// Major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		opRType  = 7'b0110011,
		opImm    = 7'b0010011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opSystem = 7'b1110011	// ECALL and EBREAK
	} opcodeE;

	// Bit 0 set means the adder subtracts (sub, slt, sltu)
	typedef enum logic [3:0] {
		aluAdd  = 4'b0000,
		aluSub  = 4'b0001,
		aluAnd  = 4'b0010,
		aluOr   = 4'b0011,
		aluXor  = 4'b0100,
		aluSlt  = 4'b0101,
		aluSll  = 4'b0110,
		aluSrl  = 4'b0111,
		aluSra  = 4'b1000,
		aluSltu = 4'b1001
	} aluOpE;

	// Immediate formats
	typedef enum logic [2:0] {
		immFmtI = 3'b000,
		immFmtS = 3'b001,
		immFmtB = 3'b010,
		immFmtU = 3'b011,
		immFmtJ = 3'b100
	} immSelE;

	// Next PC source
	typedef enum logic [1:0] {
		pcSrcPlus4  = 2'b00,
		pcSrcTarget = 2'b01,	// PC + imm
		pcSrcAlu    = 2'b10,	// JALR, rs1 + imm
		pcSrcHold   = 2'b11	// Halt on ECALL/EBREAK
	} pcSelE;

	// Writeback source
	typedef enum logic [2:0] {
		resAlu      = 3'b000,
		resMem      = 3'b001,
		resPcPlus4  = 3'b010,
		resImm      = 3'b011,	// LUI
		resPcTarget = 3'b100	// AUIPC
	} resultSelE;

	typedef struct packed {
		logic [regAddrW-1:0] rs1;
		logic [regAddrW-1:0] rs2;
		logic [regAddrW-1:0] rd;
		logic regWrite;
		logic memWrite;
		logic aluSrcImm;	// ALU operand B from imm
		aluOpE aluOp;
		resultSelE resultSel;
		logic [xlen-1:0] imm;	// Sign extended
	} decodeT;

endpackage : rvCorePkg

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f rvCore.f --top-module tbRvCore -o simRvCore || exit 1
simOut=$(./obj_dir/simRvCore)
printf '%s\n' "$simOut"
printf '%s\n' "$simOut" | grep -qx "All checks passed" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: rvCore.f
design/rvCorePkg.sv
design/alu.sv
design/regFile.sv
design/pcUnit.sv
design/controlUnit.sv
design/rvCore.sv
tests/rvCoreChecker.sv
tests/tbRvCore.sv

// File: tests/rvCoreChecker.sv
module rvCoreChecker (
	input logic clk,
	input logic rst,
	input logic [rvCorePkg::xlen-1:0] imemAddr_i,
	input logic [rvCorePkg::xlen-1:0] dmemAddr_i,
	input logic [rvCorePkg::xlen-1:0] dmemWd_i,
	input logic dmemWe_i,
	input logic [rvCorePkg::xlen-1:0] progMem_i [256],
	input logic [rvCorePkg::xlen-1:0] dataInit_i [64],
	output int errorCount_o,
	output int checkCount_o,
	output logic done_o
);
	import rvCorePkg::*;

	localparam int haltCycles = 8;

	logic [xlen-1:0] regModel [numRegs];
	logic [xlen-1:0] memModel [64];
	logic [xlen-1:0] pcModel;
	int holdCount;
	int errorCount = 0;
	int checkCount = 0;
	logic done = 1'b0;

	assign errorCount_o = errorCount;
	assign checkCount_o = checkCount;
	assign done_o = done;

	task automatic compareHex(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("ERROR %s expected %h got %h at pc %h", name, exp, got, pcModel);
		end
	endtask

	// RV32I integer semantics, alt is funct7[5]
	function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0] y;
		case (f3)
			3'd0: y = alt ? a - b : a + b;
			3'd1: y = a << b[4:0];
			3'd2: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: y = (a < b) ? 32'd1 : 32'd0;
			3'd4: y = a ^ b;
			3'd5: begin
				if (alt) y = $signed(a) >>> b[4:0];
				else y = a >> b[4:0];
			end
			3'd6: y = a | b;
			default: y = a & b;
		endcase
		return y;
	endfunction

	task automatic stepModel();
		logic [31:0] instr;
		logic [31:0] rs1v;
		logic [31:0] rs2v;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immU;
		logic [31:0] immJ;
		logic [31:0] result;
		logic [31:0] addr;
		logic [31:0] nextPc;
		logic [2:0] f3;
		logic writeRd;
		logic isStore;
		logic taken;
		compareHex("imemAddr_o", imemAddr_i, pcModel);
		if (pcModel[31:10] != '0) begin
			errorCount++;
			$display("Model PC %h ran past the end of the program", pcModel);
			done = 1'b1;
			return;
		end
		instr = progMem_i[pcModel[9:2]];
		f3 = instr[14:12];
		rs1v = regModel[instr[19:15]];
		rs2v = regModel[instr[24:20]];
		immI = {{20{instr[31]}}, instr[31:20]};
		immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
		immU = {instr[31:12], 12'b0};
		immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
		result = '0;
		writeRd = 1'b1;
		isStore = 1'b0;
		nextPc = pcModel + 32'd4;
		case (instr[6:0])
			opRType: result = aluModel(f3, instr[30], rs1v, rs2v);
			opImm: result = aluModel(f3, instr[30] && f3 == 3'd5, rs1v, immI);
			opLoad: begin
				addr = rs1v + immI;
				result = memModel[addr[7:2]];
			end
			opStore: begin
				addr = rs1v + immS;
				isStore = 1'b1;
				writeRd = 1'b0;
				compareHex("dmemWe_o", 32'(dmemWe_i), 32'd1);
				compareHex("dmemAddr_o", dmemAddr_i, addr);
				compareHex("dmemWd_o", dmemWd_i, rs2v);
				memModel[addr[7:2]] = rs2v;
			end
			opBranch: begin
				writeRd = 1'b0;
				case (f3)
					3'b000: taken = rs1v == rs2v;
					3'b001: taken = rs1v != rs2v;
					3'b100: taken = $signed(rs1v) < $signed(rs2v);
					3'b101: taken = $signed(rs1v) >= $signed(rs2v);
					3'b110: taken = rs1v < rs2v;
					default: taken = rs1v >= rs2v;
				endcase
				if (taken) nextPc = pcModel + immB;
			end
			opJal: begin
				result = pcModel + 32'd4;
				nextPc = pcModel + immJ;
			end
			opJalr: begin
				result = pcModel + 32'd4;
				nextPc = (rs1v + immI) & ~32'd1;
			end
			opLui: result = immU;
			opAuipc: result = pcModel + immU;
			default: begin	// ECALL/EBREAK halt in place
				writeRd = 1'b0;
				nextPc = pcModel;
				holdCount++;
				if (holdCount >= haltCycles) done = 1'b1;
			end
		endcase
		if (!isStore) compareHex("dmemWe_o", 32'(dmemWe_i), 32'd0);
		if (writeRd && instr[11:7] != 5'd0) regModel[instr[11:7]] = result;
		pcModel = nextPc;
	endtask

	// Mid-cycle sampling, inputs settle well before the falling edge
	always @(negedge clk) begin
		if (rst) begin
			pcModel = '0;
			holdCount = 0;
			for (int i = 0; i < numRegs; i++) regModel[i] = '0;
			for (int i = 0; i < 64; i++) memModel[i] = dataInit_i[i];
			compareHex("dmemWe_o", 32'(dmemWe_i), 32'd0);
			compareHex("imemAddr_o", imemAddr_i, 32'd0);
		end else if (!done) begin
			stepModel();
		end
	end

endmodule : rvCoreChecker

// File: tests/tbRvCore.sv
module tbRvCore;
	import rvCorePkg::*;

	localparam int clkPeriod = 4;
	localparam int imemWords = 256;
	localparam int dmemWords = 64;
	localparam int resetCycles = 16;
	localparam int maxCycles = 2 * imemWords + 64;

	logic clk;
	logic rst;
	logic [xlen-1:0] imemAddr;
	logic [xlen-1:0] imemRd;
	logic [xlen-1:0] dmemAddr;
	logic [xlen-1:0] dmemWd;
	logic [xlen-1:0] dmemRd;
	logic dmemWe;
	logic [xlen-1:0] imem [imemWords];
	logic [xlen-1:0] dmem [dmemWords];
	logic [xlen-1:0] dataInit [dmemWords];	// Preload, copied into dmem during reset
	logic [31:0] lcgState = 32'hccd191a5;
	int errorCount;
	int checkCount;
	logic done;

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// One random instruction for word idx, control flow only jumps forward
	function automatic logic [31:0] randomInstr(input int idx);
		logic [31:0] r;
		logic [31:0] s;
		logic [31:0] instr;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [11:0] imm12;
		logic [12:0] immB;
		logic [20:0] immJ;
		logic alt;
		int k;
		r = lcgNext();
		s = lcgNext();
		rd = {1'b0, r[27:24]};	// Low 16 registers so values get reused
		rs1 = {1'b0, r[23:20]};
		rs2 = {1'b0, r[19:16]};
		f3 = r[14:12];
		alt = s[31] && (f3 == 3'd0 || f3 == 3'd5);
		k = 2 + int'(s[15:0]) % 7;
		if (idx + k > imemWords - 1) k = imemWords - 1 - idx;
		immB = 13'(k * 4);
		immJ = 21'(k * 4);
		imm12 = s[27:16];
		if (f3 == 3'd1) imm12 = {7'b0, s[20:16]};
		if (f3 == 3'd5) imm12 = {1'b0, s[31], 5'b0, s[20:16]};
		case (r[31:28])
			4'd0, 4'd1, 4'd2, 4'd3: instr = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opRType};
			4'd4, 4'd5, 4'd6: instr = {imm12, rs1, f3, rd, opImm};
			4'd7: instr = {s[31:12], rd, opLui};
			4'd8: instr = {s[31:12], rd, opAuipc};
			4'd9: instr = {4'b0, s[21:16], 2'b00, 5'd0, 3'b010, rd, opLoad};
			4'd10, 4'd11: instr = {4'b0, s[21:19], rs2, 5'd0, 3'b010, s[18:16], 2'b00, opStore};
			4'd12, 4'd13: begin
				case (int'(s[23:16]) % 6)
					0: f3 = 3'b000;
					1: f3 = 3'b001;
					2: f3 = 3'b100;
					3: f3 = 3'b101;
					4: f3 = 3'b110;
					default: f3 = 3'b111;
				endcase
				instr = {immB[12], immB[10:5], rs2, rs1, f3, immB[4:1], immB[11], opBranch};
			end
			4'd14: instr = {immJ[20], immJ[10:1], immJ[11], immJ[19:12], rd, opJal};
			default: instr = {12'((idx + k) * 4), 5'd0, 3'b000, rd, opJalr};	// Absolute target
		endcase
		return instr;
	endfunction

	rvCore u_rvCore (
		.clk(clk),
		.rst(rst),
		.imemAddr_o(imemAddr),
		.imemRd_i(imemRd),
		.dmemAddr_o(dmemAddr),
		.dmemWd_o(dmemWd),
		.dmemWe_o(dmemWe),
		.dmemRd_i(dmemRd)
	);

	rvCoreChecker u_checker (
		.clk(clk),
		.rst(rst),
		.imemAddr_i(imemAddr),
		.dmemAddr_i(dmemAddr),
		.dmemWd_i(dmemWd),
		.dmemWe_i(dmemWe),
		.progMem_i(imem),
		.dataInit_i(dataInit),
		.errorCount_o(errorCount),
		.checkCount_o(checkCount),
		.done_o(done)
	);

	assign imemRd = imem[imemAddr[9:2]];
	assign dmemRd = dmem[dmemAddr[7:2]];

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < dmemWords; i++) dmem[i] <= dataInit[i];
		end else if (dmemWe) begin
			dmem[dmemAddr[7:2]] <= dmemWd;
		end
	end

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		for (int i = 0; i < imemWords - 1; i++) imem[i] = randomInstr(i);
		imem[0] = {7'd0, 5'd0, 5'd0, 3'b010, 5'd0, opStore};	// SW at the reset PC
		imem[imemWords - 1] = 32'h00000073;	// ECALL
		for (int i = 0; i < dmemWords; i++) dataInit[i] = lcgNext();
		repeat (resetCycles) @(posedge clk);
		#1 rst = 1'b0;
		wait (done);
		@(posedge clk);
		$display("Finished with %0d errors in %0d checks", errorCount, checkCount);
		if (errorCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Every instruction runs at most once, plus the halt cycles
	initial begin
		#((resetCycles + maxCycles) * clkPeriod);
		$display("Timeout: the core never reached its halt within %0d cycles", maxCycles);
		$display("Checks failed");
		$finish;
	end

endmodule : tbRvCore
